// ==== source/edp_defines.svh ====
`ifndef EDP_DEFINES_SVH
`define EDP_DEFINES_SVH

// Word format
`define EDP_WORD     36
`define EDP_HALF     18
`define EDP_SLICE    6
`define EDP_NSLICE   6
`define EDP_FMDEPTH  16

// APB register map, byte addresses on a 32-bit stride
`define ADDR_ARL     8'h00
`define ADDR_ARR     8'h04
`define ADDR_BRL     8'h08
`define ADDR_BRR     8'h0C
`define ADDR_MQL     8'h10
`define ADDR_MQR     8'h14
`define ADDR_ADL     8'h18
`define ADDR_ADR     8'h1C
`define ADDR_CMD     8'h20
`define ADDR_STATUS  8'h24
// FM window, left half at even word offsets and right half at odd ones
`define ADDR_FMBASE  8'h80

`endif

// ==== source/edpPkg.sv ====
`default_nettype none

`include "edp_defines.svh"

package edpPkg;

  // One data path word, seen whole or as two halfwords
  typedef union packed {
    logic [0:`EDP_WORD-1] word;
    struct packed {
      logic [0:`EDP_HALF-1] left;
      logic [0:`EDP_HALF-1] right;
    } half;
  } tWord;

  typedef enum logic [2:0] {
    aluADD, aluSUB, aluAND, aluOR, aluXOR, aluANDCA, aluPASSA, aluPASSB
  } tAluOp;

  typedef enum logic [1:0] {adaAR, adaMQ, adaFM, adaZERO} tAdaSel;

  typedef enum logic [1:0] {adbBR, adbBRX2, adbARX4, adbFM} tAdbSel;

  typedef enum logic [1:0] {mqHOLD, mqLOAD, mqSHL, mqSHR} tMqOp;

  // Micro-step command as written by the host, aluOp in the top bits
  typedef struct packed {
    tAluOp      aluOp;
    tAdaSel     ada;
    tAdbSel     adb;
    logic       carryIn;
    logic       arLoad;
    logic       brFromAr;
    tMqOp       mqOp;
    logic       fmWrite;
    logic [3:0] fmAddr;
  } tCmd;

endpackage

`default_nettype wire

// ==== source/operandSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "edp_defines.svh"

module operandSelect import edpPkg::*; (
  input  wire tWord   ar,
  input  wire tWord   br,
  input  wire tWord   mq,
  input  wire tWord   fmWord,
  input  wire tAdaSel ada,
  input  wire tAdbSel adb,
  output tWord        adaWord,
  output tWord        adbWord
);

  // ADA mux
  always_comb begin
    case (ada)
      adaAR:   adaWord = ar;
      adaMQ:   adaWord = mq;
      adaFM:   adaWord = fmWord;
      default: adaWord = '0;
    endcase
  end

  // ADB mux
  // Bit 0 is the sign, so a left shift drops bits off the top
  // and brings zeros in at bit 35
  always_comb begin
    case (adb)
      adbBR: begin
        adbWord = br;
      end
      adbBRX2: begin
        // BR times two
        adbWord.word = {br.word[1:`EDP_WORD-1], 1'b0};
      end
      adbARX4: begin
        // AR times four
        adbWord.word = {ar.word[2:`EDP_WORD-1], 2'b00};
      end
      default: begin
        adbWord = fmWord;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== source/aluSlice.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "edp_defines.svh"

module aluSlice import edpPkg::*; (
  input  wire logic [0:`EDP_SLICE-1] a,
  input  wire logic [0:`EDP_SLICE-1] b,
  input  wire tAluOp                 aluOp,
  input  wire logic                  cin,
  output logic [0:`EDP_SLICE-1]      f,
  output logic                       gen,
  output logic                       prop,
  output logic                       topCarry
);

  logic                   arith;
  logic [0:`EDP_SLICE-1]  bEff;
  logic [0:`EDP_SLICE-1]  bitGen;
  logic [0:`EDP_SLICE-1]  bitProp;
  logic [0:`EDP_SLICE-1]  sum;
  logic                   carry;
  logic                   chainGen;
  logic                   carryTop;

  assign arith = (aluOp == aluADD) || (aluOp == aluSUB);

  // Subtract is A plus ones complement of B plus carry in
  assign bEff    = (aluOp == aluSUB) ? ~b : b;
  assign bitGen  = a & bEff;
  assign bitProp = a ^ bEff;

  // Ripple inside the slice, LSB is bit 5
  always_comb begin
    sum      = '0;
    carry    = cin;
    chainGen = 1'b0;
    carryTop = 1'b0;
    for (int k = `EDP_SLICE - 1; k >= 0; k--) begin
      sum[k] = bitProp[k] ^ carry;
      if (k == 0) begin
        carryTop = carry;
      end
      carry    = bitGen[k] | (bitProp[k] & carry);
      chainGen = bitGen[k] | (bitProp[k] & chainGen);
    end
  end

  always_comb begin
    case (aluOp)
      aluAND:   f = a & b;
      aluOR:    f = a | b;
      aluXOR:   f = a ^ b;
      aluANDCA: f = a & ~b;
      aluPASSA: f = a;
      aluPASSB: f = b;
      default:  f = sum;
    endcase
  end

  // Boolean functions take no part in the carry network
  assign gen      = arith & chainGen;
  assign prop     = arith & (&bitProp);
  assign topCarry = arith & carryTop;

endmodule

`default_nettype wire

// ==== source/carryLookahead.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "edp_defines.svh"

module carryLookahead (
  input  wire logic [0:`EDP_NSLICE-1] gen,
  input  wire logic [0:`EDP_NSLICE-1] prop,
  input  wire logic                   topCarry,
  input  wire logic                   carryIn,
  output logic [0:`EDP_NSLICE-1]      cin,
  output logic                        carryOut,
  output logic                        overflow
);

  logic loGen;
  logic loProp;
  logic hiGen;
  logic hiProp;
  logic midCarry;

  // Second level, slices 3..5 low group and 0..2 high group
  assign loGen  = gen[3] | (prop[3] & gen[4]) | (prop[3] & prop[4] & gen[5]);
  assign loProp = prop[3] & prop[4] & prop[5];
  assign hiGen  = gen[0] | (prop[0] & gen[1]) | (prop[0] & prop[1] & gen[2]);
  assign hiProp = prop[0] & prop[1] & prop[2];

  // Carry into the high group
  assign midCarry = loGen | (loProp & carryIn);

  // First level within each group
  assign cin[5] = carryIn;
  assign cin[4] = gen[5] | (prop[5] & carryIn);
  assign cin[3] = gen[4] | (prop[4] & gen[5]) | (prop[4] & prop[5] & carryIn);
  assign cin[2] = midCarry;
  assign cin[1] = gen[2] | (prop[2] & midCarry);
  assign cin[0] = gen[1] | (prop[1] & gen[2]) | (prop[1] & prop[2] & midCarry);

  assign carryOut = hiGen | (hiProp & loGen) | (hiProp & loProp & carryIn);

  // Sign wrong when carries into and out of bit 0 differ
  assign overflow = carryOut ^ topCarry;

endmodule

`default_nettype wire

// ==== source/dataPath.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "edp_defines.svh"

module dataPath import edpPkg::*; (
  input  wire logic       CLK,
  input  wire logic       reset,
  input  wire tWord       wrData,
  input  wire logic       wrRight,
  input  wire logic       arWrite,
  input  wire logic       brWrite,
  input  wire logic       mqWrite,
  input  wire logic       fmHostWrite,
  input  wire logic [3:0] fmHostAddr,
  input  wire logic       step,
  input  wire tCmd        cmd,
  output tWord            ar,
  output tWord            br,
  output tWord            mq,
  output tWord            ad,
  output tWord            fmRead,
  output logic            carryOut,
  output logic            overflow
);

  tWord fm [0:`EDP_FMDEPTH-1];

  tWord fmWord;
  tWord adaWord;
  tWord adbWord;
  tWord adWord;

  logic [0:`EDP_NSLICE-1] gen;
  logic [0:`EDP_NSLICE-1] prop;
  logic [0:`EDP_NSLICE-1] cin;
  logic [0:`EDP_NSLICE-1] topCarry;

  logic       fmWe;
  logic       fmWeLeft;
  logic       fmWeRight;
  logic [3:0] fmWAddr;
  tWord       fmWData;

  assign fmWord = fm[cmd.fmAddr];
  assign fmRead = fm[fmHostAddr];

  operandSelect opSel (
    .ar      (ar),
    .br      (br),
    .mq      (mq),
    .fmWord  (fmWord),
    .ada     (cmd.ada),
    .adb     (cmd.adb),
    .adaWord (adaWord),
    .adbWord (adbWord)
  );

  // Slice 0 holds the sign bit, slice 5 the low six bits
  for (genvar i = 0; i < `EDP_NSLICE; i++) begin : slice
    aluSlice alu (
      .a        (adaWord.word[i*`EDP_SLICE +: `EDP_SLICE]),
      .b        (adbWord.word[i*`EDP_SLICE +: `EDP_SLICE]),
      .aluOp    (cmd.aluOp),
      .cin      (cin[i]),
      .f        (adWord.word[i*`EDP_SLICE +: `EDP_SLICE]),
      .gen      (gen[i]),
      .prop     (prop[i]),
      .topCarry (topCarry[i])
    );
  end

  carryLookahead cla (
    .gen      (gen),
    .prop     (prop),
    .topCarry (topCarry[0]),
    .carryIn  (cmd.carryIn),
    .cin      (cin),
    .carryOut (carryOut),
    .overflow (overflow)
  );

  // Single FM write port, step writes take whole words
  assign fmWe      = step ? cmd.fmWrite : fmHostWrite;
  assign fmWAddr   = step ? cmd.fmAddr : fmHostAddr;
  assign fmWData   = step ? adWord : wrData;
  assign fmWeLeft  = fmWe & (step | ~wrRight);
  assign fmWeRight = fmWe & (step | wrRight);

  always_ff @(posedge CLK) begin
    if (fmWeLeft) begin
      fm[fmWAddr].half.left <= fmWData.half.left;
    end
    if (fmWeRight) begin
      fm[fmWAddr].half.right <= fmWData.half.right;
    end
  end

  always_ff @(posedge CLK) begin
    if (reset) begin
      ar <= '0;
      br <= '0;
      mq <= '0;
      ad <= '0;
    end else if (step) begin
      ad <= adWord;
      if (cmd.arLoad) begin
        ar <= adWord;
      end
      // BR sees AR from before this step
      if (cmd.brFromAr) begin
        br <= ar;
      end
      case (cmd.mqOp)
        mqLOAD: mq <= adWord;
        mqSHL:  mq.word <= {mq.word[1:`EDP_WORD-1], carryOut};
        mqSHR:  mq.word <= {mq.word[0], mq.word[0:`EDP_WORD-2]};
        mqHOLD: mq <= mq;
      endcase
    end else begin
      // Host loads, one halfword at a time
      if (arWrite) begin
        if (wrRight) ar.half.right <= wrData.half.right;
        else ar.half.left <= wrData.half.left;
      end
      if (brWrite) begin
        if (wrRight) br.half.right <= wrData.half.right;
        else br.half.left <= wrData.half.left;
      end
      if (mqWrite) begin
        if (wrRight) mq.half.right <= wrData.half.right;
        else mq.half.left <= wrData.half.left;
      end
    end
  end

endmodule

`default_nettype wire

// ==== source/apbDiag.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "edp_defines.svh"

module apbDiag import edpPkg::*; (
  input  wire logic        CLK,
  input  wire logic        reset,
  input  wire logic        PSEL,
  input  wire logic        PENABLE,
  input  wire logic        PWRITE,
  input  wire logic [7:0]  PADDR,
  input  wire logic [31:0] PWDATA,
  output logic [31:0]      PRDATA,
  output logic             PREADY,
  output logic             PSLVERR,
  input  wire tWord        ar,
  input  wire tWord        br,
  input  wire tWord        mq,
  input  wire tWord        ad,
  input  wire tWord        fmRead,
  input  wire logic        carryOut,
  input  wire logic        overflow,
  output tWord             wrData,
  output logic             wrRight,
  output logic             arWrite,
  output logic             brWrite,
  output logic             mqWrite,
  output logic             fmHostWrite,
  output logic [3:0]       fmHostAddr,
  output logic             step,
  output tCmd              cmd
);

  logic       access;
  logic       hostWrite;
  logic [7:0] fmOffset;
  logic       fmHit;
  logic       hitArl, hitArr, hitBrl, hitBrr, hitMql, hitMqr;
  logic       hitAdl, hitAdr, hitCmd, hitStatus;
  logic       mapped;
  logic       readOnly;
  logic       rightHalf;
  tWord       curWord;
  logic [0:`EDP_HALF-1] readHalf;
  tCmd        newCmd;
  tCmd        cmdReg;
  logic [1:0] statusReg;

  assign access    = PSEL & PENABLE;
  assign hostWrite = access & PWRITE;

  // Address decode
  assign hitArl    = (PADDR == `ADDR_ARL);
  assign hitArr    = (PADDR == `ADDR_ARR);
  assign hitBrl    = (PADDR == `ADDR_BRL);
  assign hitBrr    = (PADDR == `ADDR_BRR);
  assign hitMql    = (PADDR == `ADDR_MQL);
  assign hitMqr    = (PADDR == `ADDR_MQR);
  assign hitAdl    = (PADDR == `ADDR_ADL);
  assign hitAdr    = (PADDR == `ADDR_ADR);
  assign hitCmd    = (PADDR == `ADDR_CMD);
  assign hitStatus = (PADDR == `ADDR_STATUS);

  // FM window, two halfword registers per location
  assign fmOffset   = PADDR - `ADDR_FMBASE;
  assign fmHit      = (PADDR >= `ADDR_FMBASE) && (fmOffset[1:0] == 2'b00);
  assign fmHostAddr = fmOffset[6:3];

  assign mapped   = hitArl | hitArr | hitBrl | hitBrr | hitMql | hitMqr |
                    hitAdl | hitAdr | hitCmd | hitStatus | fmHit;
  assign readOnly = hitAdl | hitAdr | hitStatus;

  assign PREADY  = 1'b1;
  assign PSLVERR = access & (~mapped | (PWRITE & readOnly));

  assign rightHalf = hitArr | hitBrr | hitMqr | hitAdr | (fmHit & fmOffset[2]);
  assign wrRight   = rightHalf;

  // Word behind the addressed halfword
  always_comb begin
    if (hitArl | hitArr) curWord = ar;
    else if (hitBrl | hitBrr) curWord = br;
    else if (hitMql | hitMqr) curWord = mq;
    else if (hitAdl | hitAdr) curWord = ad;
    else curWord = fmRead;
  end

  // Merge new half with the half that stays
  assign wrData.half.left  = rightHalf ? curWord.half.left : PWDATA[`EDP_HALF-1:0];
  assign wrData.half.right = rightHalf ? PWDATA[`EDP_HALF-1:0] : curWord.half.right;

  assign arWrite     = hostWrite & (hitArl | hitArr);
  assign brWrite     = hostWrite & (hitBrl | hitBrr);
  assign mqWrite     = hostWrite & (hitMql | hitMqr);
  assign fmHostWrite = hostWrite & fmHit;

  // Command write fires exactly one step
  assign step   = hostWrite & hitCmd;
  assign newCmd = tCmd'(PWDATA[$bits(tCmd)-1:0]);
  assign cmd    = step ? newCmd : cmdReg;

  always_ff @(posedge CLK) begin
    if (reset) begin
      cmdReg    <= '0;
      statusReg <= '0;
    end else if (step) begin
      cmdReg    <= newCmd;
      statusReg <= {overflow, carryOut};
    end
  end

  assign readHalf = rightHalf ? curWord.half.right : curWord.half.left;

  always_comb begin
    if (hitCmd) PRDATA = 32'(cmdReg);
    else if (hitStatus) PRDATA = {30'b0, statusReg};
    else if (mapped) PRDATA = 32'(readHalf);
    else PRDATA = '0;
  end

endmodule

`default_nettype wire

// ==== source/ebox.sv ====
`timescale 1ns/1ps
`default_nettype none

module ebox import edpPkg::*; (
  input  wire logic        CLK,
  input  wire logic        reset,
  input  wire logic        PSEL,
  input  wire logic        PENABLE,
  input  wire logic        PWRITE,
  input  wire logic [7:0]  PADDR,
  input  wire logic [31:0] PWDATA,
  output logic [31:0]      PRDATA,
  output logic             PREADY,
  output logic             PSLVERR
);

  tWord       ar, br, mq, ad, fmRead;
  tWord       wrData;
  logic       carryOut, overflow;
  logic       wrRight, arWrite, brWrite, mqWrite, fmHostWrite;
  logic [3:0] fmHostAddr;
  logic       step;
  tCmd        cmd;

  apbDiag diag (
    .CLK, .reset,
    .PSEL, .PENABLE, .PWRITE, .PADDR, .PWDATA,
    .PRDATA, .PREADY, .PSLVERR,
    .ar, .br, .mq, .ad, .fmRead,
    .carryOut, .overflow,
    .wrData, .wrRight, .arWrite, .brWrite, .mqWrite,
    .fmHostWrite, .fmHostAddr, .step, .cmd
  );

  dataPath edp (
    .CLK, .reset,
    .wrData, .wrRight, .arWrite, .brWrite, .mqWrite,
    .fmHostWrite, .fmHostAddr, .step, .cmd,
    .ar, .br, .mq, .ad, .fmRead,
    .carryOut, .overflow
  );

endmodule

`default_nettype wire

// ==== test/tbApbTasks.svh ====
`ifndef TB_APB_TASKS_SVH
`define TB_APB_TASKS_SVH

// Access cycles allowed before PREADY counts as lost
localparam int apbTimeout = 16;

// One APB transfer, setup phase then access phase until PREADY
task automatic apbTransfer(input logic write, input logic [7:0] addr,
                           input logic [31:0] wdata, output logic [31:0] rdata,
                           output logic err);
  int   waited;
  logic done;
  waited = 0;
  done   = 1'b0;
  rdata  = '0;
  err    = 1'b0;
  @(posedge CLK);
  PSEL    <= 1'b1;
  PENABLE <= 1'b0;
  PWRITE  <= write;
  PADDR   <= addr;
  PWDATA  <= wdata;
  @(posedge CLK);
  PENABLE <= 1'b1;
  // Sample in the middle of the cycle, the transfer ends at the next edge
  while (!done && waited < apbTimeout) begin
    @(negedge CLK);
    if (PREADY) begin
      rdata = PRDATA;
      err   = PSLVERR;
      done  = 1'b1;
    end
    waited++;
    @(posedge CLK);
  end
  if (done) begin
    PSEL    <= 1'b0;
    PENABLE <= 1'b0;
  end else begin
    $display("APB transfer to address %h saw no PREADY in %0d cycles", addr, apbTimeout);
    endRun(1'b1);
  end
endtask

task automatic apbWrite(input logic [7:0] addr, input logic [31:0] data, output logic err);
  logic [31:0] unused;
  apbTransfer(1'b1, addr, data, unused, err);
endtask

task automatic apbRead(input logic [7:0] addr, output logic [31:0] data, output logic err);
  apbTransfer(1'b0, addr, 32'h0, data, err);
endtask

// Halfword write that must be accepted
task automatic writeHalf(input logic [7:0] addr, input logic [31:0] data);
  logic err;
  apbWrite(addr, data, err);
  checkValue($sformatf("PSLVERR on write to %h", addr), 36'd0, 36'(err));
endtask

// Both halves of a word, left at addrLeft and right four bytes above
task automatic expectWord(input logic [7:0] addrLeft, input string name,
                          input logic [35:0] expected);
  logic [31:0] left;
  logic [31:0] right;
  logic        errLeft;
  logic        errRight;
  apbRead(addrLeft, left, errLeft);
  apbRead(addrLeft + 8'd4, right, errRight);
  checkValue({name, " PSLVERR"}, 36'd0, 36'({errLeft, errRight}));
  checkValue({name, " upper read bits"}, 36'd0, 36'({left[31:18], right[31:18]}));
  checkValue(name, expected, {left[17:0], right[17:0]});
endtask

`endif

// ==== test/tbEbox.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "edp_defines.svh"

module tbEbox import edpPkg::*; ();

  logic        CLK = 1'b0;
  logic        reset;
  logic        PSEL;
  logic        PENABLE;
  logic        PWRITE;
  logic [7:0]  PADDR;
  logic [31:0] PWDATA;
  logic [31:0] PRDATA;
  logic        PREADY;
  logic        PSLVERR;

  // Reference copies of the data path state
  logic [35:0] mAr;
  logic [35:0] mBr;
  logic [35:0] mMq;
  logic [35:0] mAd;
  logic [35:0] mFm [0:15];
  logic [1:0]  mStatus;

  int errors = 0;
  int checks = 0;
  int testNum = 0;
  int errorsAtStart = 0;

  always #20 CLK = ~CLK;

  ebox dut (
    .CLK     (CLK),
    .reset   (reset),
    .PSEL    (PSEL),
    .PENABLE (PENABLE),
    .PWRITE  (PWRITE),
    .PADDR   (PADDR),
    .PWDATA  (PWDATA),
    .PRDATA  (PRDATA),
    .PREADY  (PREADY),
    .PSLVERR (PSLVERR)
  );

  `include "tbApbTasks.svh"

  task automatic endRun(input logic timedOut);
    $display("Tests %0d, checks %0d, errors %0d", testNum, checks, errors);
    if (!timedOut && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  endtask

  task automatic checkValue(input string name, input logic [35:0] expected,
                            input logic [35:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("FAILED at %0t: %s expected %h, actual %h", $time, name, expected, actual);
      errors++;
    end
  endtask

  task automatic beginTest();
    testNum++;
    errorsAtStart = errors;
  endtask

  task automatic endTest(input string name);
    $display("Test %0d %s: %0d mismatches", testNum, name, errors - errorsAtStart);
  endtask

  function automatic logic [35:0] rand36();
    logic [63:0] r;
    r = {$urandom(), $urandom()};
    return r[35:0];
  endfunction

  function automatic logic [7:0] fmAddress(input int idx);
    return `ADDR_FMBASE + 8'(idx * 8);
  endfunction

  // Result in bits 35:0, carry out in 36, overflow in 37
  function automatic logic [37:0] aluModel(tAluOp op, logic [35:0] a, logic [35:0] b,
                                           logic ci);
    logic [36:0] sum;
    logic [35:0] bb;
    logic        ov;
    case (op)
      aluADD, aluSUB: begin
        bb  = (op == aluSUB) ? ~b : b;
        sum = {1'b0, a} + {1'b0, bb} + 37'(ci);
        // Operands agree in sign but the result does not
        ov  = (a[35] == bb[35]) && (sum[35] != a[35]);
        return {ov, sum};
      end
      aluAND:   return {2'b00, a & b};
      aluOR:    return {2'b00, a | b};
      aluXOR:   return {2'b00, a ^ b};
      aluANDCA: return {2'b00, a & ~b};
      aluPASSA: return {2'b00, a};
      default:  return {2'b00, b};
    endcase
  endfunction

  function automatic logic [35:0] operandA(tAdaSel sel, logic [3:0] idx);
    case (sel)
      adaAR:   return mAr;
      adaMQ:   return mMq;
      adaFM:   return mFm[idx];
      default: return '0;
    endcase
  endfunction

  function automatic logic [35:0] operandB(tAdbSel sel, logic [3:0] idx);
    case (sel)
      adbBR:   return mBr;
      adbBRX2: return {mBr[34:0], 1'b0};
      adbARX4: return {mAr[33:0], 2'b00};
      default: return mFm[idx];
    endcase
  endfunction

  function automatic tCmd makeCmd(tAluOp op, tAdaSel ada, tAdbSel adb, logic ci);
    tCmd c;
    c         = '0;
    c.aluOp   = op;
    c.ada     = ada;
    c.adb     = adb;
    c.carryIn = ci;
    return c;
  endfunction

  task automatic loadReg(input logic [7:0] addrLeft, input logic [35:0] value);
    writeHalf(addrLeft, 32'(value[35:18]));
    writeHalf(addrLeft + 8'd4, 32'(value[17:0]));
    case (addrLeft)
      `ADDR_ARL: mAr = value;
      `ADDR_BRL: mBr = value;
      `ADDR_MQL: mMq = value;
      default:   mFm[4'((addrLeft - `ADDR_FMBASE) >> 3)] = value;
    endcase
  endtask

  // One command write, then the model follows the step rules
  task automatic runStep(input tCmd c);
    logic [37:0] r;
    logic [31:0] rd;
    logic        err;
    r = aluModel(c.aluOp, operandA(c.ada, c.fmAddr), operandB(c.adb, c.fmAddr), c.carryIn);
    apbWrite(`ADDR_CMD, 32'(c), err);
    checkValue("PSLVERR on command write", 36'd0, 36'(err));
    // Command register reads back as written
    apbRead(`ADDR_CMD, rd, err);
    checkValue("CMD", 36'(c), 36'(rd));
    checkValue("CMD PSLVERR", 36'd0, 36'(err));
    // BR takes AR from before the step
    if (c.brFromAr) mBr = mAr;
    if (c.arLoad) mAr = r[35:0];
    case (c.mqOp)
      mqLOAD:  mMq = r[35:0];
      mqSHL:   mMq = {mMq[34:0], r[36]};
      mqSHR:   mMq = {mMq[35], mMq[35:1]};
      default: mMq = mMq;
    endcase
    if (c.fmWrite) mFm[c.fmAddr] = r[35:0];
    mAd     = r[35:0];
    mStatus = r[37:36];
  endtask

  task automatic verifyRegs();
    logic [31:0] st;
    logic        err;
    expectWord(`ADDR_ARL, "AR", mAr);
    expectWord(`ADDR_BRL, "BR", mBr);
    expectWord(`ADDR_MQL, "MQ", mMq);
    expectWord(`ADDR_ADL, "AD", mAd);
    apbRead(`ADDR_STATUS, st, err);
    checkValue("STATUS", 36'(mStatus), 36'(st));
    checkValue("STATUS PSLVERR", 36'd0, 36'(err));
  endtask

  task automatic expectError(input logic [7:0] addr, input logic write);
    logic [31:0] rd;
    logic        err;
    if (write) begin
      apbWrite(addr, 32'h0003ffff, err);
    end else begin
      apbRead(addr, rd, err);
    end
    checkValue($sformatf("PSLVERR at %h", addr), 36'd1, 36'(err));
  endtask

  initial begin
    tCmd         c;
    logic [35:0] v;
    void'($urandom(32'h7bee826c));
    reset   = 1'b1;
    PSEL    = 1'b0;
    PENABLE = 1'b0;
    PWRITE  = 1'b0;
    PADDR   = '0;
    PWDATA  = '0;
    mAr     = '0;
    mBr     = '0;
    mMq     = '0;
    mAd     = '0;
    mStatus = '0;
    repeat (3) @(posedge CLK);
    reset <= 1'b0;

    beginTest();
    verifyRegs();
    loadReg(`ADDR_ARL, rand36());
    loadReg(`ADDR_BRL, rand36());
    loadReg(`ADDR_MQL, rand36());
    verifyRegs();
    // Single halves, the other half must survive
    v = rand36();
    writeHalf(`ADDR_ARL, 32'(v[35:18]));
    mAr[35:18] = v[35:18];
    writeHalf(`ADDR_BRR, 32'(v[17:0]));
    mBr[17:0] = v[17:0];
    // Upper PWDATA bits are ignored
    writeHalf(`ADDR_MQL, {14'h3fff, v[35:18]});
    mMq[35:18] = v[35:18];
    verifyRegs();
    endTest("reset and halfword loads");

    beginTest();
    for (int i = 0; i < 8; i++) begin
      loadReg(`ADDR_ARL, rand36());
      loadReg(`ADDR_BRL, rand36());
      runStep(makeCmd(aluADD, adaAR, adbBR, 1'b0));
      verifyRegs();
      runStep(makeCmd(aluSUB, adaAR, adbBR, 1'b1));
      verifyRegs();
    end
    // Carry chain ending in each slice in turn, last one runs out the top
    for (int k = 1; k <= 6; k++) begin
      loadReg(`ADDR_ARL, (36'd1 << (6 * k)) - 36'd1);
      loadReg(`ADDR_BRL, 36'd1);
      runStep(makeCmd(aluADD, adaAR, adbBR, 1'b0));
      verifyRegs();
    end
    loadReg(`ADDR_ARL, 36'h7ffffffff);
    runStep(makeCmd(aluADD, adaAR, adbBR, 1'b0));
    verifyRegs();
    loadReg(`ADDR_ARL, 36'h800000000);
    runStep(makeCmd(aluSUB, adaAR, adbBR, 1'b1));
    verifyRegs();
    endTest("add and subtract");

    beginTest();
    for (int op = 2; op < 8; op++) begin
      loadReg(`ADDR_ARL, rand36());
      loadReg(`ADDR_BRL, rand36());
      runStep(makeCmd(tAluOp'(op), adaAR, adbBR, 1'b1));
      verifyRegs();
    end
    runStep(makeCmd(aluPASSB, adaAR, adbBRX2, 1'b0));
    verifyRegs();
    runStep(makeCmd(aluPASSB, adaAR, adbARX4, 1'b0));
    verifyRegs();
    runStep(makeCmd(aluADD, adaZERO, adbARX4, 1'b0));
    verifyRegs();
    runStep(makeCmd(aluADD, adaAR, adbBRX2, 1'b1));
    verifyRegs();
    endTest("boolean ops and shifted B");

    beginTest();
    for (int k = 0; k < 16; k++) begin
      loadReg(fmAddress(k), rand36());
    end
    for (int k = 0; k < 16; k++) begin
      expectWord(fmAddress(k), $sformatf("FM[%0d]", k), mFm[k]);
    end
    v = rand36();
    writeHalf(fmAddress(3) + 8'd4, 32'(v[17:0]));
    mFm[3][17:0] = v[17:0];
    expectWord(fmAddress(3), "FM[3]", mFm[3]);
    c = makeCmd(aluADD, adaFM, adbBR, 1'b0);
    c.fmAddr = 4'd5;
    runStep(c);
    verifyRegs();
    c = makeCmd(aluXOR, adaAR, adbFM, 1'b0);
    c.fmAddr = 4'd9;
    runStep(c);
    verifyRegs();
    c = makeCmd(aluSUB, adaAR, adbBR, 1'b1);
    c.arLoad   = 1'b1;
    c.brFromAr = 1'b1;
    c.fmWrite  = 1'b1;
    c.fmAddr   = 4'd12;
    runStep(c);
    verifyRegs();
    expectWord(fmAddress(12), "FM[12]", mFm[12]);
    c = makeCmd(aluPASSA, adaFM, adbBR, 1'b0);
    c.fmAddr = 4'd12;
    c.arLoad = 1'b1;
    runStep(c);
    verifyRegs();
    endTest("AR, BR and FM updates");

    beginTest();
    loadReg(`ADDR_MQL, rand36());
    c = makeCmd(aluXOR, adaAR, adbBR, 1'b0);
    runStep(c);
    verifyRegs();
    c = makeCmd(aluADD, adaAR, adbBR, 1'b0);
    c.mqOp = mqLOAD;
    runStep(c);
    verifyRegs();
    // Carry out of one shifts into bit 35
    loadReg(`ADDR_ARL, 36'hfffffffff);
    loadReg(`ADDR_BRL, 36'd1);
    c.mqOp = mqSHL;
    runStep(c);
    verifyRegs();
    loadReg(`ADDR_BRL, 36'd0);
    runStep(c);
    verifyRegs();
    loadReg(`ADDR_MQL, 36'h80000f0f0);
    c.mqOp = mqSHR;
    runStep(c);
    runStep(c);
    verifyRegs();
    loadReg(`ADDR_MQL, 36'h40000f0f1);
    runStep(c);
    verifyRegs();
    endTest("MQ operations");

    beginTest();
    expectError(8'h30, 1'b1);
    expectError(8'h82, 1'b1);
    expectError(`ADDR_ADL, 1'b1);
    expectError(`ADDR_STATUS, 1'b1);
    expectError(8'h30, 1'b0);
    verifyRegs();
    expectWord(fmAddress(0), "FM[0]", mFm[0]);
    endTest("slave errors");

    endRun(1'b0);
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+source
+incdir+test
source/edpPkg.sv
source/operandSelect.sv
source/aluSlice.sv
source/carryLookahead.sv
source/dataPath.sv
source/apbDiag.sv
source/ebox.sv
test/tbEbox.sv

// ==== Makefile ====
# Verilator build and run of the EBOX data path testbench

VERILATOR ?= verilator
TOP       ?= tbEbox
FILELIST  ?= all.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  := ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run, and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qxF -- "$(PASS_MSG)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
